// File: source/memPkg.sv
package memPkg;

    // ****************************************
    // sizes
    // ****************************************
    localparam int addrWidth = 10;   // 1 KiB data memory
    localparam int dataWidth = 32;
    localparam int tagWidth  = 4;
    localparam int waitWidth = 2;    // 0 to 3 wait cycles per byte
    localparam int fifoDepth = 4;

    // number of bytes moved by one access
    typedef enum logic [1:0] {
        lenByte = 2'd0,   // 1 byte
        lenHalf = 2'd1,   // 2 bytes
        lenWord = 2'd2    // 4 bytes
    } accLen;

    // ****************************************
    // channel payloads
    // ****************************************

    // one load or store request
    typedef struct packed {
        logic                 isStore;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;   // store data, byte 0 in the low bits
        accLen                len;
        logic [tagWidth-1:0]  tag;
    } memReq;

    // one completion, returned in request order
    typedef struct packed {
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;   // zero-extended load data, zero for stores
    } memResp;

endpackage

// File: source/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic [$clog2(memPkg::fifoDepth)-1:0]   wrPtr;
    logic [$clog2(memPkg::fifoDepth)-1:0]   rdPtr;
    logic [$clog2(memPkg::fifoDepth+1)-1:0] used;    // occupancy
    logic                                   push;
    logic                                   pop;

    payloadT mem [memPkg::fifoDepth];

    assign inReady  = (used != ($clog2(memPkg::fifoDepth+1))'(memPkg::fifoDepth));
    assign outValid = (used != '0);
    assign outData  = mem[rdPtr];

    assign push = inValid && inReady;
    assign pop  = outValid && outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            used  <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ($clog2(memPkg::fifoDepth))'(memPkg::fifoDepth - 1))
                         ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ($clog2(memPkg::fifoDepth))'(memPkg::fifoDepth - 1))
                         ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                used <= used + 1'b1;
            end else if (pop && !push) begin
                used <= used - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;   // visible at outData from the next cycle
        end
    end

endmodule

// File: source/waitTimer.sv
`timescale 1ns/1ps

module waitTimer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load,
    input  logic [memPkg::waitWidth-1:0] count,
    output logic                         expired
);

    logic [memPkg::waitWidth-1:0] remaining;   // wait cycles still to go

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= count;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // a pending load hides the old zero, so count 0 means no wait at all
    assign expired = (remaining == '0) && !load;

endmodule

// File: source/byteRam.sv
`timescale 1ns/1ps

module byteRam (
    input  logic                         clk,
    input  logic [memPkg::addrWidth-1:0] ramAddr,
    input  logic                         ramWe,
    input  logic [7:0]                   ramWdata,
    input  logic                         ramRead,
    output logic [7:0]                   ramRdata
);

    logic [7:0] mem [2**memPkg::addrWidth];

    // ****************************************
    // storage
    // ****************************************
    initial begin
        for (int i = 0; i < 2**memPkg::addrWidth; i++) begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[ramAddr] <= ramWdata;
        end
    end

    // registered read port, holds its value between reads
    always_ff @(posedge clk) begin
        if (ramRead) begin
            ramRdata <= mem[ramAddr];
        end
    end

endmodule

// File: source/memSequencer.sv
`timescale 1ns/1ps

module memSequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  memPkg::memReq                acc,
    input  logic [memPkg::waitWidth-1:0] waitCycles,
    output logic                         done,
    output logic [memPkg::dataWidth-1:0] rdata,
    // wait timer
    output logic                         load,
    output logic [memPkg::waitWidth-1:0] count,
    input  logic                         expired,
    // byte RAM
    output logic [memPkg::addrWidth-1:0] ramAddr,
    output logic                         ramWe,
    output logic [7:0]                   ramWdata,
    output logic                         ramRead,
    input  logic [7:0]                   ramRdata
);

    typedef enum logic [1:0] {
        idle,
        waiting,
        access,
        capture
    } seqState;

    seqState    state;
    logic [1:0] byteIdx;    // byte being moved, 0 is the lowest address
    logic [1:0] lastIdx;
    logic       lastByte;
    logic       nextByte;   // current byte finished, more to go
    logic       begin_;

    always_comb begin
        case (acc.len)
            memPkg::lenByte: lastIdx = 2'd0;
            memPkg::lenHalf: lastIdx = 2'd1;
            default:         lastIdx = 2'd3;
        endcase
    end

    assign begin_   = (state == idle) && start;
    assign lastByte = (byteIdx == lastIdx);
    assign nextByte = !lastByte && (((state == access) && acc.isStore) || (state == capture));

    // the timer is reloaded in front of every byte
    assign load  = begin_ || nextByte;
    assign count = waitCycles;

    assign ramAddr  = acc.addr + {{(memPkg::addrWidth - 2){1'b0}}, byteIdx};   // little-endian
    assign ramWdata = acc.data[8*byteIdx +: 8];
    assign ramWe    = (state == access) && acc.isStore;
    assign ramRead  = (state == access) && !acc.isStore;

    // ****************************************
    // byte FSM
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            byteIdx <= 2'd0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    byteIdx <= 2'd0;
                    if (start) state <= waiting;
                end
                waiting: begin
                    if (expired) state <= access;
                end
                access: begin
                    if (!acc.isStore) begin
                        state <= capture;   // RAM output settles on this edge
                    end else if (lastByte) begin
                        state <= idle;
                        done  <= 1'b1;
                    end else begin
                        state   <= waiting;
                        byteIdx <= byteIdx + 2'd1;
                    end
                end
                capture: begin
                    if (lastByte) begin
                        state <= idle;
                        done  <= 1'b1;
                    end else begin
                        state   <= waiting;
                        byteIdx <= byteIdx + 2'd1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // load data, upper bytes stay zero for short accesses
    always_ff @(posedge clk) begin
        if (begin_) begin
            rdata <= '0;
        end else if (state == capture) begin
            rdata[8*byteIdx +: 8] <= ramRdata;
        end
    end

endmodule

// File: source/dataPort.sv
`timescale 1ns/1ps

module dataPort (
    input  logic                         clk,
    input  logic                         rst,
    // request queue side
    input  logic                         qValid,
    output logic                         qReady,
    input  memPkg::memReq                qReq,
    // memory sequencer side
    output logic                         start,
    output memPkg::memReq                acc,
    input  logic                         done,
    input  logic [memPkg::dataWidth-1:0] rdata,
    // response queue side
    output logic                         pValid,
    input  logic                         pReady,
    output memPkg::memResp               pResp
);

    logic occupied;   // set at acceptance, cleared by the response transfer
    logic accept;
    logic handOff;

    // only one access at the memory at a time
    assign qReady  = ~occupied;
    assign accept  = qValid && qReady;
    assign handOff = pValid && pReady;

    // ****************************************
    // control
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            start    <= 1'b0;
            pValid   <= 1'b0;
        end else begin
            start <= accept;   // one cycle, the cycle after acceptance

            if (accept) begin
                occupied <= 1'b1;
            end else if (handOff) begin
                occupied <= 1'b0;
            end

            if (done) begin
                pValid <= 1'b1;
            end else if (handOff) begin
                pValid <= 1'b0;
            end
        end
    end

    // ****************************************
    // access and result registers
    // ****************************************
    always_ff @(posedge clk) begin
        if (accept) begin
            acc <= qReq;   // tag rides along until the result comes back
        end
        if (done) begin
            pResp.tag  <= acc.tag;
            pResp.data <= acc.isStore ? '0 : rdata;
        end
    end

endmodule

// File: source/lsuTop.sv
`timescale 1ns/1ps

module lsuTop (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         reqValid,
    output logic                         reqReady,
    input  memPkg::memReq                req,
    output logic                         respValid,
    input  logic                         respReady,
    output memPkg::memResp               resp,
    input  logic [memPkg::waitWidth-1:0] waitCycles
);

    logic                         qValid;
    logic                         qReady;
    memPkg::memReq                qReq;

    logic                         start;
    memPkg::memReq                acc;
    logic                         done;
    logic [memPkg::dataWidth-1:0] rdata;

    logic                         pValid;
    logic                         pReady;
    memPkg::memResp               pResp;

    logic                         load;
    logic [memPkg::waitWidth-1:0] count;
    logic                         expired;

    logic [memPkg::addrWidth-1:0] ramAddr;
    logic                         ramWe;
    logic [7:0]                   ramWdata;
    logic                         ramRead;
    logic [7:0]                   ramRdata;

    // ****************************************
    // request path
    // ****************************************
    syncFifo #(.payloadT(memPkg::memReq)) u_reqQ (
        .clk      (clk),
        .rst      (rst),
        .inValid  (reqValid),
        .inReady  (reqReady),
        .inData   (req),
        .outValid (qValid),
        .outReady (qReady),
        .outData  (qReq)
    );

    dataPort u_port (
        .clk    (clk),
        .rst    (rst),
        .qValid (qValid),
        .qReady (qReady),
        .qReq   (qReq),
        .start  (start),
        .acc    (acc),
        .done   (done),
        .rdata  (rdata),
        .pValid (pValid),
        .pReady (pReady),
        .pResp  (pResp)
    );

    // ****************************************
    // memory side
    // ****************************************
    memSequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .acc        (acc),
        .waitCycles (waitCycles),
        .done       (done),
        .rdata      (rdata),
        .load       (load),
        .count      (count),
        .expired    (expired),
        .ramAddr    (ramAddr),
        .ramWe      (ramWe),
        .ramWdata   (ramWdata),
        .ramRead    (ramRead),
        .ramRdata   (ramRdata)
    );

    waitTimer u_timer (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .count   (count),
        .expired (expired)
    );

    byteRam u_ram (
        .clk      (clk),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRead  (ramRead),
        .ramRdata (ramRdata)
    );

    // responses leave in request order
    syncFifo #(.payloadT(memPkg::memResp)) u_respQ (
        .clk      (clk),
        .rst      (rst),
        .inValid  (pValid),
        .inReady  (pReady),
        .inData   (pResp),
        .outValid (respValid),
        .outReady (respReady),
        .outData  (resp)
    );

endmodule

// File: testbench/lsuChecker.sv
`timescale 1ns/1ps

module lsuChecker (
    input  logic           clk,
    input  logic           rst,
    input  logic           reqValid,
    input  logic           reqReady,
    input  memPkg::memReq  req,
    input  logic [7:0]     reqTest,   // test number of the request on the bus
    input  logic           reqLast,   // last request of its test
    input  logic           respValid,
    input  logic           respReady,
    input  memPkg::memResp resp,
    output int             errCount,
    output int             respCount,
    output int             pending,
    output int             testsPassed,
    output int             testsFailed
);

    typedef struct packed {
        logic [memPkg::tagWidth-1:0]  tag;
        logic [memPkg::dataWidth-1:0] data;
        logic [7:0]                   test;
        logic                         last;
    } expEntry;

    logic [7:0] model [2**memPkg::addrWidth];   // byte image of the data memory
    expEntry    expQ [$];
    int         testErrs;
    int         testResps;
    int         resetErrs;
    logic       rstPrev;

    initial begin
        for (int i = 0; i < 2**memPkg::addrWidth; i++) begin
            model[i] = 8'h00;
        end
        errCount    = 0;
        respCount   = 0;
        pending     = 0;
        testsPassed = 0;
        testsFailed = 0;
        testErrs    = 0;
        testResps   = 0;
        resetErrs   = 0;
        rstPrev     = 1'b0;
    end

    function automatic int byteCount(logic [1:0] len);
        case (len)
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    // stores hit the model in acceptance order, loads read it the same way
    task automatic acceptReq();
        expEntry                      e;
        logic [memPkg::addrWidth-1:0] a;
        e.tag  = req.tag;
        e.data = '0;
        e.test = reqTest;
        e.last = reqLast;
        for (int i = 0; i < byteCount(req.len); i++) begin
            a = req.addr + (memPkg::addrWidth)'(i);   // wraps like the RAM
            if (req.isStore) begin
                model[a] = req.data[8*i +: 8];
            end else begin
                e.data[8*i +: 8] = model[a];
            end
        end
        expQ.push_back(e);
    endtask

    task automatic checkResp();
        expEntry e;
        respCount++;
        if (expQ.size() == 0) begin
            $display("response with tag 0x%h arrived with no request outstanding", resp.tag);
            errCount++;
            return;
        end
        e = expQ.pop_front();
        testResps++;
        if (resp.tag !== e.tag) begin
            $display("Mismatch resp.tag: expected 0x%h, got 0x%h", e.tag, resp.tag);
            errCount++;
            testErrs++;
        end
        if (resp.data !== e.data) begin
            $display("Mismatch resp.data: expected 0x%h, got 0x%h (tag 0x%h)",
                     e.data, resp.data, e.tag);
            errCount++;
            testErrs++;
        end
        if (e.last) begin
            if (testErrs == 0) begin
                $display("test %0d: pass, %0d responses", e.test, testResps);
                testsPassed++;
            end else begin
                $display("test %0d: fail, %0d mismatches in %0d responses",
                         e.test, testErrs, testResps);
                testsFailed++;
            end
            testErrs  = 0;
            testResps = 0;
        end
    endtask

    // ****************************************
    // sampling at the falling edge, values are settled here
    // ****************************************
    always @(negedge clk) begin
        if (rst || rstPrev) begin
            if (respValid !== 1'b0 || reqReady !== 1'b1) begin
                $display("reset state wrong: respValid is %b and reqReady is %b",
                         respValid, reqReady);
                errCount++;
                resetErrs++;
            end
            if (!rst) begin   // first cycle after reset closes the check
                if (resetErrs == 0) begin
                    $display("test 1: pass, reset state");
                    testsPassed++;
                end else begin
                    $display("test 1: fail, reset state");
                    testsFailed++;
                end
            end
        end
        if (!rst) begin
            if (reqValid && reqReady) acceptReq();
            if (respValid && respReady) checkResp();
        end
        pending = expQ.size();
        rstPrev = rst;
    end

endmodule

// File: testbench/lsu_props.sv
`timescale 1ns/1ps

module lsuProps (
    input logic           clk,
    input logic           rst,
    input logic           start,
    input logic           done,
    input logic           pValid,
    input logic           pReady,
    input memPkg::memResp pResp
);

    logic started;   // start seen, done still to come
    logic busy;      // start seen, response not yet handed on
    int   assertFails = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            busy    <= 1'b0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end else if (done) begin
                started <= 1'b0;
            end
            if (start) begin
                busy <= 1'b1;
            end else if (pValid && pReady) begin
                busy <= 1'b0;
            end
        end
    end

    respHeld: assert property (@(posedge clk) disable iff (rst)
        pValid && !pReady |=> $stable(pResp))
        else begin
            $error("pResp changed while pValid waited for pReady");
            assertFails++;
        end

    startWhenFree: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else begin
            $error("start rose while an access was still occupied");
            assertFails++;
        end

    doneAfterStart: assert property (@(posedge clk) disable iff (rst)
        done |-> started)
        else begin
            $error("done pulsed without a preceding start");
            assertFails++;
        end

endmodule

bind dataPort lsuProps u_props (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .done   (done),
    .pValid (pValid),
    .pReady (pReady),
    .pResp  (pResp)
);

// File: testbench/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;

    localparam int    maxLines = 64;
    localparam string stimPath = "testbench/lsuStim.txt";

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         reqValid;
    logic                         reqReady;
    memPkg::memReq                req;
    logic                         respValid;
    logic                         respReady;
    memPkg::memResp               resp;
    logic [memPkg::waitWidth-1:0] waitCycles;
    logic [7:0]                   reqTest;
    logic                         reqLast;

    int errCount;
    int respCount;
    int pending;
    int testsPassed;
    int testsFailed;
    int tbErrors;
    int nLines;
    bit loaded;
    bit finished;

    // stimulus table, one entry per stim line
    int                           stTest  [maxLines];
    logic                         stStore [maxLines];
    logic [memPkg::addrWidth-1:0] stAddr  [maxLines];
    logic [memPkg::dataWidth-1:0] stData  [maxLines];
    logic [1:0]                   stLen   [maxLines];
    logic [memPkg::tagWidth-1:0]  stTag   [maxLines];
    logic [memPkg::waitWidth-1:0] stWait  [maxLines];

    lsuTop u_dut (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .reqReady   (reqReady),
        .req        (req),
        .respValid  (respValid),
        .respReady  (respReady),
        .resp       (resp),
        .waitCycles (waitCycles)
    );

    lsuChecker u_chk (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .reqTest     (reqTest),
        .reqLast     (reqLast),
        .respValid   (respValid),
        .respReady   (respReady),
        .resp        (resp),
        .errCount    (errCount),
        .respCount   (respCount),
        .pending     (pending),
        .testsPassed (testsPassed),
        .testsFailed (testsFailed)
    );

    always #10 clk = ~clk;

    // response back-pressure, low about a third of the time
    initial begin
        void'($urandom(47347));
        forever begin
            @(posedge clk);
            #2;
            respReady = ($urandom % 3) != 0;
        end
    end

    task automatic readStim();
        int    fd;
        int    got;
        string line;
        int    t, s, a, d, l, g, w;
        nLines = 0;
        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", stimPath);
            tbErrors++;
            return;
        end
        while (!$feof(fd) && nLines < maxLines) begin
            got = $fgets(line, fd);
            if (got > 1 && line[0] != 8'h23) begin   // skip blank and # lines
                got = $sscanf(line, "%d %d %h %h %d %h %d", t, s, a, d, l, g, w);
                if (got == 7) begin
                    stTest[nLines]  = t;
                    stStore[nLines] = s[0];
                    stAddr[nLines]  = a[memPkg::addrWidth-1:0];
                    stData[nLines]  = d;
                    stLen[nLines]   = l[1:0];
                    stTag[nLines]   = g[memPkg::tagWidth-1:0];
                    stWait[nLines]  = w[memPkg::waitWidth-1:0];
                    nLines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // called 2 ns after a rising edge, returns at the same point after acceptance
    task automatic sendReq(int i);
        logic taken;
        req.isStore = stStore[i];
        req.addr    = stAddr[i];
        req.data    = stData[i];
        req.len     = memPkg::accLen'(stLen[i]);
        req.tag     = stTag[i];
        waitCycles  = stWait[i];
        reqTest     = 8'(stTest[i]);
        reqLast     = (i == nLines - 1) || (stTest[i + 1] != stTest[i]);
        reqValid    = 1'b1;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = reqReady;
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        rst        = 1'b1;
        reqValid   = 1'b0;
        req        = '0;
        waitCycles = '0;
        respReady  = 1'b0;
        reqTest    = '0;
        reqLast    = 1'b0;
        tbErrors   = 0;
        finished   = 1'b0;
        readStim();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        for (int i = 0; i < nLines; i++) begin
            sendReq(i);
        end
        reqValid = 1'b0;
        while (respCount < nLines) @(posedge clk);
        repeat (20) @(posedge clk);   // room for a duplicated response to show up
        finished = 1'b1;
        if (pending != 0) begin
            $display("%0d expected responses never arrived", pending);
            tbErrors++;
        end
        if (u_dut.u_port.u_props.assertFails != 0) begin
            $display("%0d handshake assertions failed", u_dut.u_port.u_props.assertFails);
            tbErrors++;
        end
        $display("totals: %0d tests passed, %0d failed, %0d responses, %0d errors",
                 testsPassed, testsFailed, respCount, errCount + tbErrors);
        if (errCount == 0 && tbErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // ****************************************
    // watchdog
    // ****************************************
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = nLines * 4 * (3 + 2) * 4 + 200;   // worst case bytes times wait and RAM cycles
        repeat (limit) @(posedge clk);
        if (!finished) begin
            $display("timeout after %0d cycles with %0d of %0d responses received",
                     limit, respCount, nLines);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

// File: files.f
source/memPkg.sv
source/syncFifo.sv
source/waitTimer.sv
source/byteRam.sv
source/memSequencer.sv
source/dataPort.sv
source/lsuTop.sv
testbench/lsuChecker.sv
testbench/lsu_props.sv
testbench/lsuTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the LSU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsuTb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VlsuTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "NO ERRORS" "$logFile"; then
    exit 0
fi
echo "simulation reported failures, see $logFile"
exit 1

// File: testbench/lsuStim.txt
# test store addr data len tag wait, one access per line
# addr, data and tag in hex; len 0 = byte, 1 = half, 2 = word
2 1 010 12345678 2 1 0
2 0 010 00000000 2 2 0
2 1 3f0 deadbeef 2 3 1
2 0 3f0 00000000 2 4 1
3 1 020 a1b2c3d4 2 5 0
3 1 021 000000ee 0 6 0
3 0 020 00000000 2 7 0
3 1 022 00005566 1 8 0
3 0 020 00000000 2 9 0
3 0 021 00000000 0 a 0
3 0 022 00000000 1 b 0
3 0 023 00000000 0 c 1
3 1 025 0000beef 1 d 2
3 0 024 00000000 2 e 2
4 1 040 cafef00d 2 0 0
4 0 041 00000000 1 1 0
4 1 040 cafef00d 2 2 1
4 0 041 00000000 1 3 1
4 1 040 cafef00d 2 4 2
4 0 041 00000000 1 5 2
4 1 040 cafef00d 2 6 3
4 0 041 00000000 1 7 3
5 1 100 11111111 2 0 3
5 1 104 22222222 2 1 3
5 0 100 00000000 2 2 3
5 1 108 33333333 2 3 3
5 0 104 00000000 2 4 3
5 0 108 00000000 2 5 3
5 1 101 0000007f 0 6 3
5 0 100 00000000 2 7 3
5 0 102 00000000 1 8 3
5 0 10a 00000000 1 9 3
